//--- logic/guts_pkg.sv
package guts_pkg;

  // one link channel and the node packet built from its bytes
  localparam int channel_width_lp = 8;
  localparam int ring_bytes_lp    = 10;

  typedef logic [ring_bytes_lp*channel_width_lp-1:0] node_data_t;
  typedef logic [31:0] flit_t;
  typedef logic [3:0]  cord_t;
  typedef logic [3:0]  node_id_t;

  // node packet, destination id in the top bits
  typedef struct packed {
    node_id_t destid;
    node_id_t srcid;
    logic [$bits(node_data_t)-2*$bits(node_id_t)-1:0] payload;
  } node_pkt_s;

  // wormhole header flit, router coordinate in the low bits
  typedef struct packed {
    logic [$bits(flit_t)-$bits(cord_t)-$bits(node_id_t)-1:0] payload;
    node_id_t srcid;
    cord_t    cord;
  } wh_flit_s;

  // calibration phases, in the order they are walked
  typedef enum logic [2:0] {
    phase_idle,
    phase_token,
    phase_token_off,
    phase_up_release,
    phase_down_pulse,
    phase_down_off,
    phase_core_release,
    phase_done
  } reset_phase_e;

  typedef struct packed {
    logic async_token_reset;
    logic upstream_link_reset;
    logic downstream_link_reset;
    logic core_link_reset;
  } link_resets_s;

endpackage

//--- logic/link_reset_sequencer.sv
`timescale 1ns/10ps

module link_reset_sequencer
  import guts_pkg::*;
#(
  parameter int unsigned phase_cycles_p = 32
) (
  input  logic         core_clk_i,
  input  logic         async_reset_i,
  output link_resets_s link_resets_o,
  output logic         calib_done_o,
  output logic         core_reset_o
);

  localparam int cnt_width_lp = (phase_cycles_p > 0) ? $clog2(phase_cycles_p + 1) : 1;

  // two flop synchronizer into the core domain
  logic [1:0] reset_sync_r;
  logic       sync_reset_lo;

  always_ff @(posedge core_clk_i) begin
    reset_sync_r <= {reset_sync_r[0], async_reset_i};
  end

  assign sync_reset_lo = reset_sync_r[1];

  reset_phase_e            phase_r;
  reset_phase_e            phase_n;
  logic [cnt_width_lp-1:0] cnt_r;
  logic [cnt_width_lp-1:0] cnt_n;
  logic                    cnt_at_term;

  assign cnt_at_term = (cnt_r == cnt_width_lp'(phase_cycles_p));

  // phase counter and next phase
  always_comb begin
    phase_n = phase_r;
    cnt_n   = cnt_r + 1'b1;
    if (phase_r == phase_done) begin
      // terminal phase, counter parked
      cnt_n = '0;
    end else if (cnt_at_term) begin
      cnt_n = '0;
      case (phase_r)
        phase_idle:         phase_n = phase_token;
        phase_token:        phase_n = phase_token_off;
        phase_token_off:    phase_n = phase_up_release;
        phase_up_release:   phase_n = phase_down_pulse;
        phase_down_pulse:   phase_n = phase_down_off;
        phase_down_off:     phase_n = phase_core_release;
        phase_core_release: phase_n = phase_done;
        default:            phase_n = phase_done;
      endcase
    end
  end

  always_ff @(posedge core_clk_i) begin
    if (sync_reset_lo) begin
      phase_r <= phase_idle;
      cnt_r   <= '0;
    end else begin
      phase_r <= phase_n;
      cnt_r   <= cnt_n;
    end
  end

  // link reset levels, each registered one cycle behind its phase
  logic upstream_reset_r;
  logic upstream_reset_n;
  logic downstream_reset_r;
  logic downstream_reset_n;
  logic core_link_reset_r;
  logic core_link_reset_n;

  always_comb begin
    upstream_reset_n   = upstream_reset_r;
    downstream_reset_n = downstream_reset_r;
    core_link_reset_n  = core_link_reset_r;
    case (phase_r)
      phase_up_release:   upstream_reset_n   = 1'b0;
      phase_down_pulse:   downstream_reset_n = 1'b1;
      phase_down_off:     downstream_reset_n = 1'b0;
      phase_core_release: core_link_reset_n  = 1'b0;
      default: begin
      end
    endcase
  end

  always_ff @(posedge core_clk_i) begin
    if (sync_reset_lo) begin
      upstream_reset_r   <= 1'b1;
      downstream_reset_r <= 1'b0;
      core_link_reset_r  <= 1'b1;
    end else begin
      upstream_reset_r   <= upstream_reset_n;
      downstream_reset_r <= downstream_reset_n;
      core_link_reset_r  <= core_link_reset_n;
    end
  end

  // token reset is a straight decode of the phase
  assign link_resets_o.async_token_reset     = (phase_r == phase_token);
  assign link_resets_o.upstream_link_reset   = upstream_reset_r;
  assign link_resets_o.downstream_link_reset = downstream_reset_r;
  assign link_resets_o.core_link_reset       = core_link_reset_r;

  // post-calibration reset for the core
  assign calib_done_o = (phase_r == phase_done);
  assign core_reset_o = ~calib_done_o;

endmodule

//--- logic/node_dest_tagger.sv
`timescale 1ns/10ps

module node_dest_tagger
  import guts_pkg::*;
#(
  parameter bit          master_p      = 1'b0,
  parameter int unsigned cord_offset_p = 4
) (
  input  logic       core_clk_i,
  input  logic       calib_done_i,

  // node side handshake is valid with yumi
  input  logic       node_v_i,
  input  node_data_t node_data_i,
  output logic       node_yumi_o,

  // flit side handshake is valid with ready
  output logic       flit_v_o,
  output flit_t      flit_o,
  input  logic       flit_ready_i
);

  node_pkt_s node_pkt_li;
  cord_t     dest_cord;
  wh_flit_s  flit_n;
  wh_flit_s  flit_r;
  logic      flit_v_r;
  logic      stage_free;

  assign node_pkt_li = node_data_i;

  // master side routes with an offset while the client side routes directly
  always_comb begin
    if (master_p) begin
      dest_cord = node_pkt_li.destid + cord_t'(cord_offset_p);
    end else begin
      dest_cord = node_pkt_li.destid;
    end
  end

  always_comb begin
    flit_n.payload = node_pkt_li.payload[$bits(flit_n.payload)-1:0];
    flit_n.srcid   = node_pkt_li.srcid;
    flit_n.cord    = dest_cord;
  end

  // free when empty or when the held flit leaves this cycle
  assign stage_free  = calib_done_i & (~flit_v_r | flit_ready_i);
  assign node_yumi_o = node_v_i & stage_free;

  // stage stays empty until calibration completes
  always_ff @(posedge core_clk_i) begin
    if (~calib_done_i) begin
      flit_v_r <= 1'b0;
    end else if (stage_free) begin
      flit_v_r <= node_v_i;
    end
  end

  // flit held unchanged while ready is low
  always_ff @(posedge core_clk_i) begin
    if (node_yumi_o) begin
      flit_r <= flit_n;
    end
  end

  // no valid flit leaves while calibration is incomplete
  assign flit_v_o = flit_v_r & calib_done_i;
  assign flit_o   = flit_r;

endmodule

//--- logic/guts_top.sv
`timescale 1ns/10ps

module guts_top
  import guts_pkg::*;
#(
  parameter int unsigned phase_cycles_p = 32,
  parameter bit          master_p       = 1'b0,
  parameter int unsigned cord_offset_p  = 4
) (
  input  logic         core_clk_i,
  input  logic         async_reset_i,

  // node packets in
  input  logic         node_v_i,
  input  node_data_t   node_data_i,
  output logic         node_yumi_o,

  // header flits out
  output logic         flit_v_o,
  output flit_t        flit_o,
  input  logic         flit_ready_i,

  // link resets and post-calibration core reset
  output link_resets_s link_resets_o,
  output logic         core_reset_o
);

  logic calib_done_lo;

  link_reset_sequencer #(
    .phase_cycles_p(phase_cycles_p)
  ) link_reset_sequencer_inst (
    .core_clk_i   (core_clk_i),
    .async_reset_i(async_reset_i),
    .link_resets_o(link_resets_o),
    .calib_done_o (calib_done_lo),
    .core_reset_o (core_reset_o)
  );

  // node traffic held off until calibration completes
  node_dest_tagger #(
    .master_p     (master_p),
    .cord_offset_p(cord_offset_p)
  ) node_dest_tagger_inst (
    .core_clk_i  (core_clk_i),
    .calib_done_i(calib_done_lo),
    .node_v_i    (node_v_i),
    .node_data_i (node_data_i),
    .node_yumi_o (node_yumi_o),
    .flit_v_o    (flit_v_o),
    .flit_o      (flit_o),
    .flit_ready_i(flit_ready_i)
  );

endmodule

//--- test/guts_tb.sv
`timescale 1ns/10ps

module guts_tb
  import guts_pkg::*;
();

  localparam int phase_cycles_lp = 7;
  localparam int reset_cycles_lp = 4;
  // two flop synchronizer puts the first free edge two edges after release
  localparam int sync_edge_lp    = reset_cycles_lp + 2;
  localparam int margin_lp       = 8;

  logic         core_clk_i = 1'b0;
  logic         async_reset_i;
  logic         node_v_i;
  node_data_t   node_data_i;
  logic         node_yumi_o;
  logic         flit_v_o;
  flit_t        flit_o;
  logic         flit_ready_i;
  link_resets_s link_resets_o;
  logic         core_reset_o;

  logic [79:0] pkt_q[$];
  int          gap_q[$];
  int          stall_q[$];
  logic [31:0] exp_q[$];

  int          edge_cnt    = 0;
  int          cycle_limit = 100000;
  int          yumi_count  = 0;
  int          xfer_count  = 0;
  logic        held_v      = 1'b0;
  logic [31:0] held_flit   = '0;

  guts_top #(
    .phase_cycles_p(phase_cycles_lp)
  ) guts_top_inst (
    .core_clk_i   (core_clk_i),
    .async_reset_i(async_reset_i),
    .node_v_i     (node_v_i),
    .node_data_i  (node_data_i),
    .node_yumi_o  (node_yumi_o),
    .flit_v_o     (flit_v_o),
    .flit_o       (flit_o),
    .flit_ready_i (flit_ready_i),
    .link_resets_o(link_resets_o),
    .core_reset_o (core_reset_o)
  );

  always #4 core_clk_i = ~core_clk_i;

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      report_failure($sformatf("MISMATCH %s: got 0x%0h, expected 0x%0h",
                               name, actual, expected));
    end
  endtask

  // {token, upstream, downstream, core link, core reset} at n cycles after sync release
  // negative n gives the levels held in reset
  function automatic logic [4:0] expected_resets(input int n);
    int         per;
    logic [4:0] r;
    per  = phase_cycles_lp + 1;
    r[4] = (n >= per) && (n < 2*per);
    r[3] = (n < 3*per + 1);
    r[2] = (n >= 4*per + 1) && (n < 5*per + 1);
    r[1] = (n < 6*per + 1);
    r[0] = (n < 7*per);
    return r;
  endfunction

  task automatic check_resets(input int n);
    logic [4:0] exp_bits;
    exp_bits = expected_resets(n);
    check_value("async_token_reset", link_resets_o.async_token_reset, exp_bits[4]);
    check_value("upstream_link_reset", link_resets_o.upstream_link_reset, exp_bits[3]);
    check_value("downstream_link_reset", link_resets_o.downstream_link_reset, exp_bits[2]);
    check_value("core_link_reset", link_resets_o.core_link_reset, exp_bits[1]);
    check_value("core_reset_o", core_reset_o, exp_bits[0]);
    // node side stays shut during calibration
    if (exp_bits[0]) begin
      check_value("node_yumi_o", node_yumi_o, 1'b0);
      check_value("flit_v_o", flit_v_o, 1'b0);
    end
  endtask

  always @(posedge core_clk_i) begin
    edge_cnt <= edge_cnt + 1;
    if (edge_cnt > cycle_limit) begin
      report_failure("timeout: flits did not all arrive within the cycle limit");
    end
  end

  // outputs sampled on the falling edge
  always @(negedge core_clk_i) begin
    if (edge_cnt >= 3) begin
      check_resets(edge_cnt - sync_edge_lp);
      if (node_yumi_o) begin
        yumi_count++;
      end
      if (held_v) begin
        check_value("flit_v_o (held)", flit_v_o, 1'b1);
        check_value("flit_o (held)", flit_o, held_flit);
      end
      if (flit_v_o && flit_ready_i) begin
        if (xfer_count >= exp_q.size()) begin
          report_failure("an extra flit was transferred after the last packet");
        end else begin
          check_value("flit_o", flit_o, exp_q[xfer_count]);
          xfer_count++;
        end
      end
      held_v    = flit_v_o && !flit_ready_i;
      held_flit = flit_o;
    end
  end

  task automatic drive_packets();
    int   i;
    logic taken;
    for (i = 0; i < pkt_q.size(); i++) begin
      if (gap_q[i] > 0) begin
        node_v_i <= 1'b0;
        repeat (gap_q[i]) @(posedge core_clk_i);
      end
      node_v_i    <= 1'b1;
      node_data_i <= pkt_q[i];
      taken = 1'b0;
      while (!taken) begin
        @(negedge core_clk_i);
        taken = node_yumi_o;
        @(posedge core_clk_i);
      end
    end
    node_v_i <= 1'b0;
  endtask

  task automatic accept_flits();
    int   i;
    int   stalls;
    logic seen;
    for (i = 0; i < exp_q.size(); i++) begin
      flit_ready_i <= 1'b0;
      stalls = stall_q[i] + int'($urandom % 3);
      seen   = 1'b0;
      while (!seen) begin
        @(negedge core_clk_i);
        seen = flit_v_o;
        @(posedge core_clk_i);
      end
      repeat (stalls) @(posedge core_clk_i);
      flit_ready_i <= 1'b1;
      @(posedge core_clk_i);
    end
  endtask

  initial begin
    int          fd;
    int          i;
    int          n_fields;
    string       line;
    string       pkt_tail;
    logic [31:0] tail_val;
    logic [79:0] pkt;
    int          gap;
    int          stall;
    logic [31:0] flit_exp;
    void'($urandom(32'h203b_be58));
    async_reset_i = 1'b1;
    node_v_i      = 1'b0;
    node_data_i   = '0;
    flit_ready_i  = 1'b0;

    fd = $fopen("test/guts_stimulus.txt", "r");
    if (fd == 0) begin
      report_failure("could not open test/guts_stimulus.txt");
    end
    while ($fgets(line, fd)) begin
      if (line.len() < 2 || line[0] == "#") begin
        continue;
      end
      n_fields = $sscanf(line, "%h %d %d %h", pkt, gap, stall, flit_exp);
      if (n_fields != 4) begin
        // packet digits written in two groups
        n_fields = $sscanf(line, "%h %s %d %d %h", pkt, pkt_tail, gap, stall, flit_exp);
        if (n_fields != 5 || pkt_tail.len() == 0 || pkt_tail.len() > 8) begin
          report_failure("malformed line in the stimulus file");
        end else begin
          tail_val = pkt_tail.atohex();
          pkt      = (pkt << (4 * pkt_tail.len())) | 80'(tail_val);
        end
      end
      pkt_q.push_back(pkt);
      gap_q.push_back(gap);
      stall_q.push_back(stall);
      exp_q.push_back(flit_exp);
    end
    $fclose(fd);
    if (pkt_q.size() == 0) begin
      report_failure("the stimulus file holds no packets");
    end

    // calibration walk plus a budget per packet
    cycle_limit = sync_edge_lp + 7*(phase_cycles_lp + 1) + 16;
    for (i = 0; i < pkt_q.size(); i++) begin
      cycle_limit += gap_q[i] + stall_q[i] + margin_lp;
    end

    repeat (reset_cycles_lp) @(posedge core_clk_i);
    async_reset_i <= 1'b0;

    fork
      drive_packets();
      accept_flits();
    join

    repeat (4) @(posedge core_clk_i);
    @(negedge core_clk_i);
    check_value("transferred flit count", xfer_count, exp_q.size());
    check_value("yumi count", yumi_count, xfer_count);
    check_value("flit_v_o after last flit", flit_v_o, 1'b0);
    $display("TEST OK");
    $finish;
  end

endmodule

//--- sources.f
logic/guts_pkg.sv
logic/link_reset_sequencer.sv
logic/node_dest_tagger.sv
logic/guts_top.sv
test/guts_tb.sv

//--- Bender.yml
package:
  name: guts

sources:
  - logic/guts_pkg.sv
  - logic/link_reset_sequencer.sv
  - logic/node_dest_tagger.sv
  - logic/guts_top.sv
  - target: test
    files:
      - test/guts_tb.sv

//--- test/guts_stimulus.txt
# columns: packet (hex, destid srcid payload), idle gap before it, ready stall count,
# expected header flit (hex, payload[23:0] srcid cord)
120000a10000005c3e07 0 0 5c3e0721
34ffee0123ab4567cd89 0 2 67cd8943
0f000000000000000001 1 0 000001f0
f0123456789abcdef012 0 3 def0120f
55aaaaaabbbbbbcccccc 2 1 cccccc55
71010203040506070809 0 0 07080917
89deadbeefcafef00d42 0 4 f00d4298
ab112233445566778899 3 0 778899ba
cdfedcba9876543210ff 0 1 3210ffdc
e2000000ffffff000000 1 2 0000002e
63a5a5a55a5a5aa5a5a5 0 0 a5a5a536
265a5a5aa5a5a55a5a5a 0 0 5a5a5a62
9813579bdf02468ace13 2 2 8ace1389
baffffffffffff fffffe 0 1 fffffeab
4c0badc0de0123456789 0 3 456789c4
dec0ffeebeef00abcdef 1 0 abcdefed
11111111222222333333 0 0 33333311
37900000000000000009 0 2 00000973
5b246802468024680246 3 1 680246b5
7dfedcba0123456789ab 0 0 6789abd7
ffffffffffffffffffff 0 4 ffffffff
00000000000000000000 1 1 00000000
c4314159265358979323 0 0 9793234c
82271828182845904523 2 0 90452328
e9aabbccddeeff001122 0 2 0011229e
6a8badf00d1234feed55 0 1 feed55a6
a50f0f0ff0f0f00f0f0f 1 3 0f0f0f5a
2c123123456456789789 0 0 789789c2
93abcabcdefdef012012 0 1 01201239
4676543210fedcba9876 2 2 ba987664
